/* verilog/ili9341_pkg.sv */
package ili9341_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] status_t;

    // ILI9341 command opcodes
    typedef enum logic [7:0] {
        cmd_swreset = 8'h01,
        cmd_rddst   = 8'h09,
        cmd_slpout  = 8'h11,
        cmd_dispon  = 8'h29,
        cmd_caset   = 8'h2A,
        cmd_paset   = 8'h2B,
        cmd_ramwr   = 8'h2C,
        cmd_madctl  = 8'h36,
        cmd_colmod  = 8'h3A
    } ili_cmd_e;

    typedef enum logic [3:0] {
        hw_reset_hold,
        hw_reset_release,
        send,                                    // table byte out
        wait_delay,
        rd_status,
        frame_start,                             // ramwr for each frame
        stream
    } seq_state_e;

    localparam logic dc_command = 1'b0;
    localparam logic dc_data    = 1'b1;

    // bit 5 row/col exchange, bit 3 RGB order
    localparam byte_t madctl_value = 8'h28;

    localparam byte_t pixel_format_rgb565 = 8'h55; // 16 bit per pixel

    localparam status_t invalid_display_status = 32'hFFFF_FFFF;

endpackage

/* verilog/frame_fetch.sv */
`timescale 1ns/1ns

module frame_fetch #(
    parameter int display_x       = 320,
    parameter int display_y       = 240,
    parameter int downscale_shift = 0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               pix_req,
    input  ili9341_pkg::byte_t mem_in,
    input  logic               mem_ready,
    output logic               pix_ack,
    output ili9341_pkg::byte_t pix_byte,
    output logic               pix_last,
    output ili9341_pkg::addr_t mem_addr,
    output logic               mem_req
);
    import ili9341_pkg::*;

    localparam int x_w = (display_x > 1) ? $clog2(display_x) : 1;
    localparam int y_w = (display_y > 1) ? $clog2(display_y) : 1;
    localparam int y_stride = (display_x >> downscale_shift) * 2; // bytes per scaled row

    typedef enum logic [2:0] {
        fetch_idle,
        fetch_col,
        fetch_row,
        fetch_mem,
        fetch_ack
    } fetch_state_e;

    fetch_state_e state;
    logic [x_w-1:0] x;
    logic [y_w-1:0] y;
    logic           byte_idx;
    logic [x_w-1:0] dx;
    logic [y_w-1:0] dy;
    logic           at_last;

    assign at_last = byte_idx && (x == x_w'(display_x - 1)) && (y == y_w'(display_y - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= fetch_idle;
            x        <= '0;
            y        <= '0;
            byte_idx <= 1'b0;
            mem_req  <= 1'b0;
            pix_ack  <= 1'b0;
            pix_last <= 1'b0;
        end
        else
        begin
            case (state)
                fetch_idle:
                begin
                    if (pix_req)
                    begin
                        dx    <= x >> downscale_shift;
                        dy    <= y >> downscale_shift;
                        state <= fetch_col;
                    end
                end
                fetch_col:
                begin
                    mem_addr <= addr_t'(byte_idx) + addr_t'(dx) * 2;
                    state    <= fetch_row;
                end
                fetch_row:
                begin
                    mem_addr <= mem_addr + addr_t'(dy) * addr_t'(y_stride);
                    mem_req  <= 1'b1;
                    state    <= fetch_mem;
                end
                fetch_mem:
                begin
                    if (mem_ready)
                    begin
                        mem_req  <= 1'b0;
                        pix_byte <= mem_in;
                        pix_last <= at_last;
                        pix_ack  <= 1'b1;
                        state    <= fetch_ack;
                    end
                end
                default: // fetch_ack
                begin
                    if (!pix_req)
                    begin
                        pix_ack  <= 1'b0;
                        pix_last <= 1'b0;
                        byte_idx <= ~byte_idx;
                        if (byte_idx)
                        begin
                            if (x == x_w'(display_x - 1))
                            begin
                                x <= '0;
                                y <= (y == y_w'(display_y - 1)) ? '0 : y + 1'b1; // new frame
                            end
                            else
                                x <= x + 1'b1;
                        end
                        state <= fetch_idle;
                    end
                end
            endcase
        end
    end

endmodule

/* verilog/display_sequencer.sv */
`timescale 1ns/1ns

module display_sequencer #(
    parameter int clk_freq_hz = 100000000,
    parameter int display_x   = 320,
    parameter int display_y   = 240
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tx_ack,
    input  ili9341_pkg::byte_t   rx_byte,
    input  logic                 pix_ack,
    input  ili9341_pkg::byte_t   pix_byte,
    input  logic                 pix_last,
    output logic                 tx_req,
    output ili9341_pkg::byte_t   tx_byte,
    output logic                 tx_dc,
    output logic                 tx_last,
    output logic                 pix_req,
    output logic                 dis_reset,
    output ili9341_pkg::status_t display_status,
    output logic                 frame_ended
);
    import ili9341_pkg::*;

    localparam int hold_count    = clk_freq_hz / 100000;     // 10 us
    localparam int release_count = clk_freq_hz / 200;        // 5 ms
    localparam int swreset_count = clk_freq_hz / 200;        // 5 ms
    localparam int slpout_count  = clk_freq_hz / 1000 * 120; // 120 ms
    localparam int timer_w       = $clog2(slpout_count + 1);

    localparam logic [15:0] last_col  = 16'(display_x - 1);
    localparam logic [15:0] last_page = 16'(display_y - 1);

    // table positions that change the flow
    localparam logic [4:0] idx_swreset     = 5'd0;
    localparam logic [4:0] idx_slpout      = 5'd1;
    localparam logic [4:0] idx_rddst       = 5'd7;
    localparam logic [4:0] idx_status_last = 5'd12;
    localparam logic [4:0] idx_paset_last  = 5'd22;
    localparam logic [4:0] idx_ramwr       = 5'd23;

    seq_state_e         state;
    logic [timer_w-1:0] timer;
    logic [4:0]         idx;
    logic [23:0]        status_shift;
    byte_t              table_byte;
    logic               table_dc;
    logic               table_last;
    byte_t              pix_data;
    logic               pix_data_last;
    logic               pix_held;
    logic               tx_idle;
    logic               tx_done;

    assign tx_idle = !tx_req && !tx_ack;
    assign tx_done = tx_req && tx_ack;

    always_comb
    begin
        table_dc   = dc_data;
        table_last = 1'b0;
        case (idx)
            5'd0:    begin table_byte = cmd_swreset; table_dc = dc_command; table_last = 1'b1; end
            5'd1:    begin table_byte = cmd_slpout; table_dc = dc_command; table_last = 1'b1; end
            5'd2:    begin table_byte = cmd_madctl; table_dc = dc_command; end
            5'd3:    begin table_byte = madctl_value; table_last = 1'b1; end
            5'd4:    begin table_byte = cmd_colmod; table_dc = dc_command; end
            5'd5:    begin table_byte = pixel_format_rgb565; table_last = 1'b1; end
            5'd6:    begin table_byte = cmd_dispon; table_dc = dc_command; table_last = 1'b1; end
            5'd7:    begin table_byte = cmd_rddst; table_dc = dc_command; end
            5'd12:   begin table_byte = 8'h00; table_last = 1'b1; end
            5'd13:   begin table_byte = cmd_caset; table_dc = dc_command; end
            5'd16:   table_byte = last_col[15:8];
            5'd17:   begin table_byte = last_col[7:0]; table_last = 1'b1; end
            5'd18:   begin table_byte = cmd_paset; table_dc = dc_command; end
            5'd21:   table_byte = last_page[15:8];
            5'd22:   begin table_byte = last_page[7:0]; table_last = 1'b1; end
            5'd23:   begin table_byte = cmd_ramwr; table_dc = dc_command; end // cs held for pixels
            default: table_byte = 8'h00; // status dummies and window start
        endcase
    end

    assign tx_byte = (state == stream) ? pix_data : table_byte;
    assign tx_dc   = (state == stream) ? dc_data : table_dc;
    assign tx_last = (state == stream) ? pix_data_last : table_last;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state          <= hw_reset_hold;
            timer          <= timer_w'(hold_count - 1);
            idx            <= '0;
            tx_req         <= 1'b0;
            pix_req        <= 1'b0;
            pix_held       <= 1'b0;
            dis_reset      <= 1'b1;
            display_status <= invalid_display_status;
            frame_ended    <= 1'b0;
        end
        else
        begin
            case (state)
                hw_reset_hold:
                begin
                    dis_reset <= 1'b0;
                    if (!dis_reset && timer == '0)
                    begin
                        dis_reset <= 1'b1;
                        timer     <= timer_w'(release_count - 1);
                        state     <= hw_reset_release;
                    end
                    else if (!dis_reset)
                        timer <= timer - 1'b1;
                end
                hw_reset_release, wait_delay:
                begin
                    if (timer == '0)
                        state <= send;
                    else
                        timer <= timer - 1'b1;
                end
                send, rd_status, frame_start:
                begin
                    if (tx_idle)
                    begin
                        tx_req <= 1'b1;
                        if (state == frame_start)
                            frame_ended <= 1'b0;
                    end
                    else if (tx_done)
                    begin
                        tx_req <= 1'b0;
                        if (state == rd_status)
                            status_shift <= {status_shift[15:0], rx_byte};
                        if (idx == idx_ramwr)
                            state <= stream;
                        else
                        begin
                            idx <= idx + 1'b1;
                            if (idx == idx_swreset)
                            begin
                                timer <= timer_w'(swreset_count - 1);
                                state <= wait_delay;
                            end
                            else if (idx == idx_slpout)
                            begin
                                timer <= timer_w'(slpout_count - 1);
                                state <= wait_delay;
                            end
                            else if (idx == idx_rddst)
                                state <= rd_status;
                            else if (idx == idx_status_last)
                            begin
                                display_status <= {status_shift, rx_byte}; // dummy shifted out
                                state          <= send;
                            end
                            else if (idx == idx_paset_last)
                                state <= frame_start;
                        end
                    end
                end
                default: // stream
                begin
                    if (!pix_held)
                    begin
                        if (!pix_req && !pix_ack)
                            pix_req <= 1'b1;
                        else if (pix_req && pix_ack)
                        begin
                            pix_req       <= 1'b0;
                            pix_data      <= pix_byte;
                            pix_data_last <= pix_last;
                            pix_held      <= 1'b1;
                        end
                    end
                    else if (tx_idle)
                        tx_req <= 1'b1;
                    else if (tx_done)
                    begin
                        tx_req   <= 1'b0;
                        pix_held <= 1'b0;
                        if (pix_data_last)
                        begin
                            frame_ended <= 1'b1;
                            state       <= frame_start;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* verilog/spi_byte_port.sv */
`timescale 1ns/1ns

module spi_byte_port (
    input  logic               clk,
    input  logic               reset,
    input  logic               tx_req,
    input  ili9341_pkg::byte_t tx_byte,
    input  logic               tx_dc,
    input  logic               tx_last,
    input  logic               spi_busy,
    input  ili9341_pkg::byte_t spi_in,
    output logic               tx_ack,
    output ili9341_pkg::byte_t rx_byte,
    output logic               cs,
    output logic               dc,
    output ili9341_pkg::byte_t spi_out,
    output logic               spi_start
);
    import ili9341_pkg::*;

    typedef enum logic [1:0] {
        port_idle,
        port_start,                              // start held until busy seen
        port_busy,
        port_ack
    } port_state_e;

    port_state_e state;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= port_idle;
            cs        <= 1'b1;
            dc        <= dc_command;
            spi_start <= 1'b0;
            tx_ack    <= 1'b0;
        end
        else
        begin
            case (state)
                port_idle:
                begin
                    if (tx_req && !spi_busy)
                    begin
                        cs        <= 1'b0;
                        dc        <= tx_dc;
                        spi_out   <= tx_byte;
                        spi_start <= 1'b1;
                        state     <= port_start;
                    end
                end
                port_start:
                begin
                    if (spi_busy)
                    begin
                        spi_start <= 1'b0;
                        state     <= port_busy;
                    end
                end
                port_busy:
                begin
                    if (!spi_busy)
                    begin
                        rx_byte <= spi_in;
                        tx_ack  <= 1'b1;
                        cs      <= tx_last; // release at end of group
                        state   <= port_ack;
                    end
                end
                default: // port_ack
                begin
                    if (!tx_req)
                    begin
                        tx_ack <= 1'b0;
                        state  <= port_idle;
                    end
                end
            endcase
        end
    end

endmodule

/* verilog/ili9341_ctrl.sv */
`timescale 1ns/1ns

module ili9341_ctrl #(
    parameter int clk_freq_hz     = 100000000,
    parameter int display_x       = 320,
    parameter int display_y       = 240,
    parameter int downscale_shift = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 spi_busy,
    input  ili9341_pkg::byte_t   spi_in,
    input  ili9341_pkg::byte_t   mem_in,
    input  logic                 mem_ready,
    output logic                 dis_reset,
    output logic                 dc,
    output logic                 cs,
    output logic                 spi_start,
    output ili9341_pkg::byte_t   spi_out,
    output ili9341_pkg::addr_t   mem_addr,
    output logic                 mem_req,
    output ili9341_pkg::status_t display_status,
    output logic                 frame_ended
);
    import ili9341_pkg::*;

    // sequencer to byte port
    logic  tx_req;
    logic  tx_ack;
    byte_t tx_byte;
    logic  tx_dc;
    logic  tx_last;
    byte_t rx_byte;

    // sequencer to frame fetch
    logic  pix_req;
    logic  pix_ack;
    byte_t pix_byte;
    logic  pix_last;

    frame_fetch #(
        .display_x      (display_x),
        .display_y      (display_y),
        .downscale_shift(downscale_shift)
    ) frame_fetch_inst (
        .clk      (clk),
        .reset    (reset),
        .pix_req  (pix_req),
        .mem_in   (mem_in),
        .mem_ready(mem_ready),
        .pix_ack  (pix_ack),
        .pix_byte (pix_byte),
        .pix_last (pix_last),
        .mem_addr (mem_addr),
        .mem_req  (mem_req)
    );

    display_sequencer #(
        .clk_freq_hz(clk_freq_hz),
        .display_x  (display_x),
        .display_y  (display_y)
    ) display_sequencer_inst (
        .clk           (clk),
        .reset         (reset),
        .tx_ack        (tx_ack),
        .rx_byte       (rx_byte),
        .pix_ack       (pix_ack),
        .pix_byte      (pix_byte),
        .pix_last      (pix_last),
        .tx_req        (tx_req),
        .tx_byte       (tx_byte),
        .tx_dc         (tx_dc),
        .tx_last       (tx_last),
        .pix_req       (pix_req),
        .dis_reset     (dis_reset),
        .display_status(display_status),
        .frame_ended   (frame_ended)
    );

    spi_byte_port spi_byte_port_inst (
        .clk      (clk),
        .reset    (reset),
        .tx_req   (tx_req),
        .tx_byte  (tx_byte),
        .tx_dc    (tx_dc),
        .tx_last  (tx_last),
        .spi_busy (spi_busy),
        .spi_in   (spi_in),
        .tx_ack   (tx_ack),
        .rx_byte  (rx_byte),
        .cs       (cs),
        .dc       (dc),
        .spi_out  (spi_out),
        .spi_start(spi_start)
    );

endmodule

/* dv/ili9341_checker.sv */
`timescale 1ns/1ns

module ili9341_checker #(
    parameter int display_x       = 8,
    parameter int display_y       = 4,
    parameter int downscale_shift = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               cs,
    input  logic               dc,
    input  logic               spi_start,
    input  ili9341_pkg::byte_t spi_out,
    input  logic               mem_req,
    input  ili9341_pkg::addr_t mem_addr
);
    import ili9341_pkg::*;

    int    test_count = 0;
    int    error_count = 0;
    int    byte_count;
    int    addr_count;
    int    idle_run;                             // cycles since spi_start was last high
    byte_t cap_byte;
    logic  cap_dc;
    logic  cap_cs;                               // cs just before the start
    int    cap_idle;
    logic  prev_start;
    logic  prev_cs;
    logic  prev_mem_req;
    int    sx;
    int    sy;
    int    sb;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        test_count++;
        if (expected !== actual)
        begin
            error_count++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
        else
            $display("pass %s value %h", name, actual);
    endtask

    // packs {cs before start, dc, byte}
    task automatic check_byte(input string name, input logic exp_dc, input byte_t exp_byte,
                              input logic exp_cs);
        compare(name, {exp_cs, exp_dc, exp_byte}, {cap_cs, cap_dc, cap_byte});
    endtask

    task automatic check_at_least(input string name, input int minimum);
        test_count++;
        if (cap_idle < minimum)
        begin
            error_count++;
            $display("CHECK FAILED %s expected >= %0d actual %0d", name, minimum, cap_idle);
        end
        else
            $display("pass %s idle cycles %0d", name, cap_idle);
    endtask

    task automatic report_timeout(input string what);
        test_count++;
        error_count++;
        $display("timed out while waiting for %s", what);
    endtask

    task automatic print_counts();
        $display("%0d tests run, %0d passed, %0d failed", test_count,
                 test_count - error_count, error_count);
    endtask

    function automatic addr_t scan_addr(input int x, input int y, input int b);
        return addr_t'(b + 2 * (x >> downscale_shift)
                       + (y >> downscale_shift) * 2 * (display_x >> downscale_shift));
    endfunction

    always @(posedge clk)
    begin
        if (reset)
        begin
            prev_start   <= 1'b0;
            prev_cs      <= 1'b1;
            prev_mem_req <= 1'b0;
            idle_run     <= 0;
            byte_count   <= 0;
            addr_count   <= 0;
            sx           <= 0;
            sy           <= 0;
            sb           <= 0;
        end
        else
        begin
            prev_start   <= spi_start;
            prev_cs      <= cs;
            prev_mem_req <= mem_req;
            idle_run     <= spi_start ? 0 : idle_run + 1;
            if (spi_start && !prev_start)
            begin
                cap_byte   <= spi_out;
                cap_dc     <= dc;
                cap_cs     <= prev_cs;
                cap_idle   <= idle_run;
                byte_count <= byte_count + 1;
            end
            if (mem_req && !prev_mem_req)
            begin
                compare($sformatf("mem_addr %0d", addr_count), scan_addr(sx, sy, sb), mem_addr);
                addr_count <= addr_count + 1;
                sb         <= 1 - sb;
                if (sb == 1)
                begin
                    sx <= (sx == display_x - 1) ? 0 : sx + 1;
                    if (sx == display_x - 1)
                        sy <= (sy == display_y - 1) ? 0 : sy + 1; // next frame
                end
            end
        end
    end

endmodule

/* dv/ili9341_ctrl_tb.sv */
`timescale 1ns/1ns

module ili9341_ctrl_tb;
    import ili9341_pkg::*;

    localparam int clk_freq_hz     = 100000;
    localparam int display_x       = 8;
    localparam int display_y       = 4;
    localparam int downscale_shift = 1;
    localparam int drive_delay     = 10;
    localparam int wait_limit      = 20000;   // cycles, covers the sleep-out delay
    localparam int frame_bytes     = display_x * display_y * 2;

    logic    clk = 1'b0;
    logic    reset;
    logic    spi_busy;
    byte_t   spi_in;
    byte_t   mem_in;
    logic    mem_ready;
    logic    dis_reset;
    logic    dc;
    logic    cs;
    logic    spi_start;
    byte_t   spi_out;
    addr_t   mem_addr;
    logic    mem_req;
    status_t display_status;
    logic    frame_ended;

    logic [31:0] lcg_state = 32'h79e1_f120;
    byte_t       spi_log[$];                  // spi_in per finished byte
    bit          timed_out = 1'b0;

    // expected init sequence
    string step_name[$];
    byte_t step_byte[$];
    logic  step_dc[$];
    int    step_idle[$];                      // min idle cycles before the byte
    int    dummy_pos[$];

    ili9341_ctrl #(
        .clk_freq_hz    (clk_freq_hz),
        .display_x      (display_x),
        .display_y      (display_y),
        .downscale_shift(downscale_shift)
    ) ili9341_ctrl_inst (
        .clk           (clk),
        .reset         (reset),
        .spi_busy      (spi_busy),
        .spi_in        (spi_in),
        .mem_in        (mem_in),
        .mem_ready     (mem_ready),
        .dis_reset     (dis_reset),
        .dc            (dc),
        .cs            (cs),
        .spi_start     (spi_start),
        .spi_out       (spi_out),
        .mem_addr      (mem_addr),
        .mem_req       (mem_req),
        .display_status(display_status),
        .frame_ended   (frame_ended)
    );

    ili9341_checker #(
        .display_x      (display_x),
        .display_y      (display_y),
        .downscale_shift(downscale_shift)
    ) checker_inst (
        .clk      (clk),
        .reset    (reset),
        .cs       (cs),
        .dc       (dc),
        .spi_start(spi_start),
        .spi_out  (spi_out),
        .mem_req  (mem_req),
        .mem_addr (mem_addr)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_step(input string name, input byte_t value, input logic dc_value,
                            input int min_idle);
        step_name.push_back(name);
        step_byte.push_back(value);
        step_dc.push_back(dc_value);
        step_idle.push_back(min_idle);
    endtask

    task automatic build_table();
        add_step("swreset", 8'h01, 1'b0, 0);
        add_step("slpout", 8'h11, 1'b0, 500);
        add_step("madctl", 8'h36, 1'b0, 12000);
        add_step("madctl data", 8'h28, 1'b1, 0);
        add_step("colmod", 8'h3A, 1'b0, 0);
        add_step("colmod data", 8'h55, 1'b1, 0);
        add_step("dispon", 8'h29, 1'b0, 0);
        add_step("rddst", 8'h09, 1'b0, 0);
        repeat (5)
            add_step("rddst dummy", 8'h00, 1'b1, 0);
        add_step("caset", 8'h2A, 1'b0, 0);
        add_step("caset start hi", 8'h00, 1'b1, 0);
        add_step("caset start lo", 8'h00, 1'b1, 0);
        add_step("caset end hi", 8'h00, 1'b1, 0);
        add_step("caset end lo", 8'h07, 1'b1, 0);
        add_step("paset", 8'h2B, 1'b0, 0);
        add_step("paset start hi", 8'h00, 1'b1, 0);
        add_step("paset start lo", 8'h00, 1'b1, 0);
        add_step("paset end hi", 8'h00, 1'b1, 0);
        add_step("paset end lo", 8'h03, 1'b1, 0);
        add_step("ramwr", 8'h2C, 1'b0, 0);
    endtask

    task automatic wait_byte_count(input int count, input string what);
        int n;
        n = 0;
        while (checker_inst.byte_count < count && n < wait_limit)
        begin
            @(posedge clk);
            #drive_delay;
            n++;
        end
        if (checker_inst.byte_count < count)
        begin
            checker_inst.report_timeout(what);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_dis_reset(input logic level);
        int n;
        n = 0;
        while (dis_reset !== level && n < wait_limit)
        begin
            @(posedge clk);
            #drive_delay;
            n++;
        end
        if (dis_reset !== level)
        begin
            checker_inst.report_timeout($sformatf("dis_reset to become %b", level));
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_frame_ended(input logic level);
        int n;
        n = 0;
        while (frame_ended !== level && n < wait_limit)
        begin
            @(posedge clk);
            #drive_delay;
            n++;
        end
        if (frame_ended !== level)
        begin
            checker_inst.report_timeout($sformatf("frame_ended to become %b", level));
            timed_out = 1'b1;
        end
    endtask

    // SPI engine, busy for 8 cycles per byte
    initial
    begin
        spi_busy = 1'b0;
        spi_in   = '0;
        forever
        begin
            @(posedge clk);
            #drive_delay;
            if (spi_start && !spi_busy && !reset)
            begin
                spi_busy = 1'b1;
                repeat (8)
                    @(posedge clk);
                #drive_delay;
                lcg_state = lcg_next(lcg_state);
                spi_in    = lcg_state[23:16];
                spi_log.push_back(spi_in);
                spi_busy  = 1'b0;
            end
        end
    end

    // frame memory, answers on the second edge
    initial
    begin
        mem_ready = 1'b0;
        mem_in    = '0;
        forever
        begin
            @(posedge clk);
            #drive_delay;
            mem_ready = 1'b0;
            if (mem_req && !reset)
            begin
                @(posedge clk);
                #drive_delay;
                mem_in    = mem_addr[7:0] ^ 8'h5A;
                mem_ready = 1'b1;
            end
        end
    end

    initial
    begin
        int    i;
        int    n;
        int    px;
        int    py;
        int    pb;
        addr_t a;
        reset = 1'b1;
        build_table();
        repeat (8)
            @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        begin : run_tests
            checker_inst.compare("reset cs", 1, cs);
            checker_inst.compare("reset spi_start", 0, spi_start);
            checker_inst.compare("reset mem_req", 0, mem_req);
            checker_inst.compare("reset frame_ended", 0, frame_ended);
            checker_inst.compare("reset display_status", 32'hFFFF_FFFF, display_status);
            wait_dis_reset(1'b0);
            if (timed_out)
                disable run_tests;
            wait_dis_reset(1'b1);
            if (timed_out)
                disable run_tests;
            checker_inst.compare("no byte during hw reset", 0, checker_inst.byte_count);

            for (i = 0; i < step_name.size(); i++)
            begin
                wait_byte_count(i + 1, step_name[i]);
                if (timed_out)
                    disable run_tests;
                checker_inst.check_byte(step_name[i], step_dc[i], step_byte[i], !step_dc[i]);
                if (step_idle[i] > 0)
                    checker_inst.check_at_least({step_name[i], " delay"}, step_idle[i]);
                if (step_name[i] == "rddst dummy")
                    dummy_pos.push_back(i);
            end
            // the first dummy byte is shifted out of the status word
            checker_inst.compare("display_status",
                {spi_log[dummy_pos[1]], spi_log[dummy_pos[2]],
                 spi_log[dummy_pos[3]], spi_log[dummy_pos[4]]}, display_status);

            n = step_name.size();
            for (py = 0; py < display_y; py++)
                for (px = 0; px < display_x; px++)
                    for (pb = 0; pb < 2; pb++)
                    begin
                        a = pb + 2 * (px >> downscale_shift)
                            + (py >> downscale_shift) * 2 * (display_x >> downscale_shift);
                        wait_byte_count(n + 1, $sformatf("pixel byte %0d", n));
                        if (timed_out)
                            disable run_tests;
                        checker_inst.check_byte($sformatf("pixel byte %0d", n), 1'b1,
                                                a[7:0] ^ 8'h5A, 1'b0);
                        n++;
                    end
            checker_inst.compare("frame_ended low in frame", 0, frame_ended);
            wait_frame_ended(1'b1);
            if (timed_out)
                disable run_tests;
            checker_inst.compare("frame_ended after last byte", frame_bytes,
                                 checker_inst.byte_count - step_name.size());

            wait_byte_count(n + 1, "second ramwr");
            if (timed_out)
                disable run_tests;
            checker_inst.check_byte("ramwr frame 2", 1'b0, 8'h2C, 1'b1);
            checker_inst.compare("frame_ended low at frame 2", 0, frame_ended);
            wait_byte_count(n + 2, "first pixel of frame 2");
            if (timed_out)
                disable run_tests;
            checker_inst.check_byte("frame 2 pixel byte 0", 1'b1, 8'h00 ^ 8'h5A, 1'b0);
        end
        checker_inst.print_counts();
        if (checker_inst.error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* ili9341_ctrl.f */
verilog/ili9341_pkg.sv
verilog/frame_fetch.sv
verilog/display_sequencer.sv
verilog/spi_byte_port.sv
verilog/ili9341_ctrl.sv
dv/ili9341_checker.sv
dv/ili9341_ctrl_tb.sv
